// ==== hw/axi_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_arbiter (
	input  logic clock,
	input  logic reset,

	// upstream request valids
	input  logic inst_ar_valid_i,
	input  logic data_ar_valid_i,
	input  logic data_aw_valid_i,
	input  logic data_w_valid_i,

	// upstream request readies, high only in the accept cycle
	output logic inst_ar_ready_o,
	output logic data_ar_ready_o,
	output logic data_aw_ready_o,
	output logic data_w_ready_o,

	// response valids from the slave
	input  logic axi_r_valid_i,
	input  logic axi_b_valid_i,

	// response readies from the upstream ports
	input  logic inst_r_ready_i,
	input  logic data_r_ready_i,
	input  logic data_b_ready_i,

	// response valids steered to the owner
	output logic inst_r_valid_o,
	output logic data_r_valid_o,
	output logic data_b_valid_o,

	// response readies back to the slave
	output logic axi_r_ready_o,
	output logic axi_b_ready_o,

	// outbound channels still waiting for their ready
	input  logic ar_busy_i,
	input  logic aw_busy_i,
	input  logic w_busy_i,

	// accept pulses to the request latch
	output logic grant_data_o,
	output logic grant_inst_o,
	output logic grant_write_o
);

	import axi_ctl_pkg::*;

	arb_state_t state_q;
	arb_state_t state_d;
	logic       write_q;   // current data txn is a store

	logic       any_busy;
	logic       idle;
	logic       want_write;
	logic       want_read;
	logic       want_inst;
	logic       grant_read;
	logic       rsp_open;
	logic       inst_txn;
	logic       rd_txn;
	logic       wr_txn;
	logic       rsp_done;

	assign any_busy = ar_busy_i | aw_busy_i | w_busy_i;

	// no new grant while an address or data beat is still on the bus
	assign idle = (state_q == ARB_IDLE) & ~any_busy;

	// a store needs both address and data present
	assign want_write = data_aw_valid_i & data_w_valid_i;
	assign want_read  = data_ar_valid_i;
	assign want_inst  = inst_ar_valid_i;

	// fixed priority: write > read > fetch
	assign grant_write_o = idle & want_write;
	assign grant_read    = idle & ~want_write & want_read;
	assign grant_inst_o  = idle & ~want_write & ~want_read & want_inst;
	assign grant_data_o  = grant_write_o | grant_read;

	// readies come from the grant alone, nothing from the slave side
	assign data_aw_ready_o = grant_write_o;
	assign data_w_ready_o  = grant_write_o;
	assign data_ar_ready_o = grant_read;
	assign inst_ar_ready_o = grant_inst_o;

	// response phase only opens once the outbound beats are gone
	assign rsp_open = ~any_busy;

	assign inst_txn = (state_q == ARB_INST);
	assign rd_txn   = (state_q == ARB_DATA) & ~write_q;
	assign wr_txn   = (state_q == ARB_DATA) & write_q;

	// slave response steered to its owner
	assign inst_r_valid_o = rsp_open & inst_txn & axi_r_valid_i;
	assign data_r_valid_o = rsp_open & rd_txn & axi_r_valid_i;
	assign data_b_valid_o = rsp_open & wr_txn & axi_b_valid_i;

	// owner's ready goes back out, others see zero
	assign axi_r_ready_o = rsp_open & ((inst_txn & inst_r_ready_i) |
		(rd_txn & data_r_ready_i));
	assign axi_b_ready_o = rsp_open & wr_txn & data_b_ready_i;

	// completion on the upstream handshake, any resp code
	assign rsp_done = (inst_r_valid_o & inst_r_ready_i) |
		(data_r_valid_o & data_r_ready_i) |
		(data_b_valid_o & data_b_ready_i);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (grant_data_o) begin
					state_d = ARB_DATA;
				end else if (grant_inst_o) begin
					state_d = ARB_INST;
				end
			end
			ARB_DATA, ARB_INST: begin
				if (rsp_done) begin
					state_d = ARB_IDLE; // back to idle next cycle
				end
			end
			default: state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ARB_IDLE;
			write_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (grant_data_o) begin
				write_q <= grant_write_o; // wait on b instead of r
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/axi_ctl_macros.svh ====
`ifndef AXI_CTL_MACROS_SVH
`define AXI_CTL_MACROS_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// address map seen by the core
`define SERIAL_PORT 32'ha000_03f8 // uart tx register
`define RTC_ADDR    32'ha000_0048 // clint mtime low word, high word follows

// crossbar device select
`define DEV_SRAM  2'd0
`define DEV_UART  2'd1
`define DEV_CLINT 2'd2

// requester ids on the master bus
`define ID_IFU 4'd0 // fetch
`define ID_LSU 4'd1 // load/store

// axi size codes
`define SIZE_WORD 3'd2 // 4 bytes per beat

`endif

// ==== hw/axi_ctl_pkg.sv ====
`default_nettype none

`include "axi_ctl_macros.svh"

package axi_ctl_pkg;

	// plain vectors
	typedef logic [`AXI_ADDR_W-1:0]   addr_t;
	typedef logic [`AXI_DATA_W-1:0]   data_t;
	typedef logic [`AXI_DATA_W/8-1:0] strb_t; // one bit per byte lane
	typedef logic [2:0]               size_t;
	typedef logic [1:0]               resp_t; // okay/exokay/slverr/decerr
	typedef logic [3:0]               id_t;
	typedef logic [1:0]               dev_t;  // xbar target

	// address channel, shared by ar and aw
	typedef struct packed {
		addr_t addr;
		id_t   id;
		size_t size;
	} ar_t;

	// write data, single beat so no last
	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_t;

	// read response
	typedef struct packed {
		data_t data;
		resp_t resp;
		id_t   id;
	} r_t;

	// write response
	typedef struct packed {
		resp_t resp;
		id_t   id;
	} b_t;

	// who owns the bus right now
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_DATA, // lsu read or write
		ARB_INST  // fetch
	} arb_state_t;

endpackage

`default_nettype wire

// ==== hw/axi_ctl_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_ctl_top (
	input  logic               clock,
	input  logic               reset,

	// fetch port
	input  logic               inst_ar_valid_i,
	input  axi_ctl_pkg::addr_t inst_ar_addr_i,
	output logic               inst_ar_ready_o,
	output axi_ctl_pkg::r_t    inst_r_o,
	output logic               inst_r_valid_o,
	input  logic               inst_r_ready_i,

	// lsu port
	input  axi_ctl_pkg::ar_t   data_ar_i,
	input  logic               data_ar_valid_i,
	output logic               data_ar_ready_o,
	output axi_ctl_pkg::r_t    data_r_o,
	output logic               data_r_valid_o,
	input  logic               data_r_ready_i,
	input  axi_ctl_pkg::ar_t   data_aw_i,
	input  logic               data_aw_valid_i,
	output logic               data_aw_ready_o,
	input  axi_ctl_pkg::w_t    data_w_i,
	input  logic               data_w_valid_i,
	output logic               data_w_ready_o,
	output axi_ctl_pkg::b_t    data_b_o,
	output logic               data_b_valid_o,
	input  logic               data_b_ready_i,

	// axi master towards the crossbar
	output axi_ctl_pkg::dev_t  device_o,
	output axi_ctl_pkg::ar_t   axi_ar_o,
	output logic               axi_ar_valid_o,
	input  logic               axi_ar_ready_i,
	input  axi_ctl_pkg::r_t    axi_r_i,
	input  logic               axi_r_valid_i,
	output logic               axi_r_ready_o,
	output axi_ctl_pkg::ar_t   axi_aw_o,
	output logic               axi_aw_valid_o,
	input  logic               axi_aw_ready_i,
	output axi_ctl_pkg::w_t    axi_w_o,
	output logic               axi_w_valid_o,
	input  logic               axi_w_ready_i,
	input  axi_ctl_pkg::b_t    axi_b_i,
	input  logic               axi_b_valid_i,
	output logic               axi_b_ready_o
);

	import axi_ctl_pkg::*;

	ar_t  inst_ar;     // fetch address, id and size filled in by the latch
	logic grant_data;
	logic grant_inst;
	logic grant_write;
	dev_t inst_dev;
	dev_t rd_dev;
	dev_t wr_dev;
	logic ar_busy;
	logic aw_busy;
	logic w_busy;

	assign inst_ar = '{addr: inst_ar_addr_i, id: '0, size: '0};

	// payloads fan out, only the owner sees a valid
	assign inst_r_o = axi_r_i;
	assign data_r_o = axi_r_i;
	assign data_b_o = axi_b_i;

	axi_arbiter axi_arbiter_i (
		.clock           (clock),
		.reset           (reset),
		.inst_ar_valid_i (inst_ar_valid_i),
		.data_ar_valid_i (data_ar_valid_i),
		.data_aw_valid_i (data_aw_valid_i),
		.data_w_valid_i  (data_w_valid_i),
		.inst_ar_ready_o (inst_ar_ready_o),
		.data_ar_ready_o (data_ar_ready_o),
		.data_aw_ready_o (data_aw_ready_o),
		.data_w_ready_o  (data_w_ready_o),
		.axi_r_valid_i   (axi_r_valid_i),
		.axi_b_valid_i   (axi_b_valid_i),
		.inst_r_ready_i  (inst_r_ready_i),
		.data_r_ready_i  (data_r_ready_i),
		.data_b_ready_i  (data_b_ready_i),
		.inst_r_valid_o  (inst_r_valid_o),
		.data_r_valid_o  (data_r_valid_o),
		.data_b_valid_o  (data_b_valid_o),
		.axi_r_ready_o   (axi_r_ready_o),
		.axi_b_ready_o   (axi_b_ready_o),
		.ar_busy_i       (ar_busy),
		.aw_busy_i       (aw_busy),
		.w_busy_i        (w_busy),
		.grant_data_o    (grant_data),
		.grant_inst_o    (grant_inst),
		.grant_write_o   (grant_write)
	);

	device_decoder device_decoder_i (
		.inst_addr_i (inst_ar_addr_i),
		.rd_addr_i   (data_ar_i.addr),
		.wr_addr_i   (data_aw_i.addr),
		.inst_dev_o  (inst_dev),
		.rd_dev_o    (rd_dev),
		.wr_dev_o    (wr_dev)
	);

	request_latch request_latch_i (
		.clock          (clock),
		.reset          (reset),
		.grant_data_i   (grant_data),
		.grant_inst_i   (grant_inst),
		.grant_write_i  (grant_write),
		.inst_ar_i      (inst_ar),
		.data_ar_i      (data_ar_i),
		.data_aw_i      (data_aw_i),
		.data_w_i       (data_w_i),
		.inst_dev_i     (inst_dev),
		.rd_dev_i       (rd_dev),
		.wr_dev_i       (wr_dev),
		.axi_ar_o       (axi_ar_o),
		.axi_aw_o       (axi_aw_o),
		.axi_w_o        (axi_w_o),
		.axi_ar_valid_o (axi_ar_valid_o),
		.axi_aw_valid_o (axi_aw_valid_o),
		.axi_w_valid_o  (axi_w_valid_o),
		.axi_ar_ready_i (axi_ar_ready_i),
		.axi_aw_ready_i (axi_aw_ready_i),
		.axi_w_ready_i  (axi_w_ready_i),
		.device_o       (device_o),
		.ar_busy_o      (ar_busy),
		.aw_busy_o      (aw_busy),
		.w_busy_o       (w_busy)
	);

endmodule

`default_nettype wire

// ==== hw/device_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_ctl_macros.svh"

module device_decoder (
	input  axi_ctl_pkg::addr_t inst_addr_i,
	input  axi_ctl_pkg::addr_t rd_addr_i,
	input  axi_ctl_pkg::addr_t wr_addr_i,
	output axi_ctl_pkg::dev_t  inst_dev_o,
	output axi_ctl_pkg::dev_t  rd_dev_o,
	output axi_ctl_pkg::dev_t  wr_dev_o
);

	import axi_ctl_pkg::*;

	// reads of the two mtime words go to the clint
	function automatic dev_t read_dev(input addr_t addr);
		if (addr == `RTC_ADDR || addr == `RTC_ADDR + 32'd4) begin
			return `DEV_CLINT;
		end
		return `DEV_SRAM;
	endfunction

	// only the tx register is uart, writes elsewhere land in sram
	function automatic dev_t write_dev(input addr_t addr);
		if (addr == `SERIAL_PORT) begin
			return `DEV_UART;
		end
		return `DEV_SRAM;
	endfunction

	// decoded every cycle, the latch picks the one that got granted
	assign inst_dev_o = read_dev(inst_addr_i); // fetch is a read too
	assign rd_dev_o   = read_dev(rd_addr_i);
	assign wr_dev_o   = write_dev(wr_addr_i);

endmodule

`default_nettype wire

// ==== hw/request_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_ctl_macros.svh"

module request_latch (
	input  logic                 clock,
	input  logic                 reset,

	// accept pulses from the arbiter
	input  logic                 grant_data_i,
	input  logic                 grant_inst_i,
	input  logic                 grant_write_i,

	// upstream payloads
	input  axi_ctl_pkg::ar_t     inst_ar_i,
	input  axi_ctl_pkg::ar_t     data_ar_i,
	input  axi_ctl_pkg::ar_t     data_aw_i,
	input  axi_ctl_pkg::w_t      data_w_i,

	// decoded targets
	input  axi_ctl_pkg::dev_t    inst_dev_i,
	input  axi_ctl_pkg::dev_t    rd_dev_i,
	input  axi_ctl_pkg::dev_t    wr_dev_i,

	// outbound master channels
	output axi_ctl_pkg::ar_t     axi_ar_o,
	output axi_ctl_pkg::ar_t     axi_aw_o,
	output axi_ctl_pkg::w_t      axi_w_o,
	output logic                 axi_ar_valid_o,
	output logic                 axi_aw_valid_o,
	output logic                 axi_w_valid_o,
	input  logic                 axi_ar_ready_i,
	input  logic                 axi_aw_ready_i,
	input  logic                 axi_w_ready_i,
	output axi_ctl_pkg::dev_t    device_o,

	// pending flags for the arbiter
	output logic                 ar_busy_o,
	output logic                 aw_busy_o,
	output logic                 w_busy_o
);

	logic grant_read; // data grant that is not a store

	assign grant_read = grant_data_i & ~grant_write_i;

	// valids rise the cycle after accept, each drops on its own ready
	always_ff @(posedge clock) begin
		if (reset) begin
			axi_ar_valid_o <= 1'b0;
			axi_aw_valid_o <= 1'b0;
			axi_w_valid_o  <= 1'b0;
			device_o       <= `DEV_SRAM;
		end else begin
			if (grant_inst_i | grant_read) begin
				axi_ar_valid_o <= 1'b1;
			end else if (axi_ar_ready_i) begin
				axi_ar_valid_o <= 1'b0;
			end
			if (grant_write_i) begin
				axi_aw_valid_o <= 1'b1;
				axi_w_valid_o  <= 1'b1;
			end else begin
				if (axi_aw_ready_i) axi_aw_valid_o <= 1'b0;
				if (axi_w_ready_i)  axi_w_valid_o  <= 1'b0; // w may finish before aw
			end
			// select stays put until the next grant
			if (grant_write_i) begin
				device_o <= wr_dev_i;
			end else if (grant_read) begin
				device_o <= rd_dev_i;
			end else if (grant_inst_i) begin
				device_o <= inst_dev_i;
			end
		end
	end

	// payload capture
	always_ff @(posedge clock) begin
		if (grant_inst_i) begin
			axi_ar_o.addr <= inst_ar_i.addr;
			axi_ar_o.id   <= `ID_IFU;
			axi_ar_o.size <= `SIZE_WORD; // fetch is always a full word
		end else if (grant_read) begin
			axi_ar_o.addr <= data_ar_i.addr;
			axi_ar_o.id   <= `ID_LSU;
			axi_ar_o.size <= data_ar_i.size; // lsu keeps its byte/half/word size
		end
		if (grant_write_i) begin
			axi_aw_o.addr <= data_aw_i.addr;
			axi_aw_o.id   <= `ID_LSU;
			axi_aw_o.size <= data_aw_i.size;
			axi_w_o       <= data_w_i; // data and strobe unchanged
		end
	end

	assign ar_busy_o = axi_ar_valid_o;
	assign aw_busy_o = axi_aw_valid_o;
	assign w_busy_o  = axi_w_valid_o;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module axi_ctl_tb -f src.f -o axi_ctl_sim

output=$(./obj_dir/axi_ctl_sim)
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
	exit 0
fi
exit 1

// ==== src.f ====
+incdir+hw
hw/axi_ctl_pkg.sv
hw/axi_arbiter.sv
hw/device_decoder.sv
hw/request_latch.sv
hw/axi_ctl_top.sv
tests/axi_ctl_checker.sv
tests/axi_ctl_tb.sv

// ==== tests/axi_ctl_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_ctl_macros.svh"

module axi_ctl_checker #(
	parameter axi_ctl_pkg::data_t rsp_key = '0
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               inst_ar_valid_i,
	input  axi_ctl_pkg::addr_t inst_ar_addr_i,
	input  logic               inst_ar_ready_o,
	input  axi_ctl_pkg::r_t    inst_r_o,
	input  logic               inst_r_valid_o,
	input  logic               inst_r_ready_i,
	input  axi_ctl_pkg::ar_t   data_ar_i,
	input  logic               data_ar_valid_i,
	input  logic               data_ar_ready_o,
	input  axi_ctl_pkg::r_t    data_r_o,
	input  logic               data_r_valid_o,
	input  logic               data_r_ready_i,
	input  axi_ctl_pkg::ar_t   data_aw_i,
	input  logic               data_aw_valid_i,
	input  logic               data_aw_ready_o,
	input  axi_ctl_pkg::w_t    data_w_i,
	input  logic               data_w_valid_i,
	input  logic               data_w_ready_o,
	input  axi_ctl_pkg::b_t    data_b_o,
	input  logic               data_b_valid_o,
	input  logic               data_b_ready_i,
	input  axi_ctl_pkg::dev_t  device_o,
	input  axi_ctl_pkg::ar_t   axi_ar_o,
	input  logic               axi_ar_valid_o,
	input  logic               axi_ar_ready_i,
	input  axi_ctl_pkg::r_t    axi_r_i,
	input  logic               axi_r_ready_o,
	input  axi_ctl_pkg::ar_t   axi_aw_o,
	input  logic               axi_aw_valid_o,
	input  logic               axi_aw_ready_i,
	input  axi_ctl_pkg::w_t    axi_w_o,
	input  logic               axi_w_valid_o,
	input  logic               axi_w_ready_i,
	input  axi_ctl_pkg::b_t    axi_b_i,
	input  logic               axi_b_ready_o,
	output int                 errors_o,
	output int                 done_o
);

	import axi_ctl_pkg::*;

	int          owner;    // 0 none, 1 fetch, 2 read, 3 write
	int          exp_kind;
	int          got_kind;
	addr_t       t_addr;
	size_t       t_size;
	w_t          t_w;
	dev_t        t_dev;
	logic        ar_exp;   // outbound beats still owed
	logic        aw_exp;
	logic        w_exp;
	logic        hold [3]; // response stalled last sample
	logic [37:0] last [3];

	// uart only for the tx register on writes, clint for both mtime words on reads
	function automatic dev_t map_dev(input addr_t a, input logic wr);
		if (wr) return (a == `SERIAL_PORT) ? `DEV_UART : `DEV_SRAM;
		return (a == `RTC_ADDR || a == `RTC_ADDR + 32'd4) ? `DEV_CLINT : `DEV_SRAM;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		errors_o++;
	endtask

	task automatic report_error(input string msg);
		$display("error at %0t: %s", $time, msg);
		errors_o++;
	endtask

	// p: 0 fetch r, 1 data r, 2 data b
	task automatic check_response(input int p, input logic v, input logic rdy,
		input logic [37:0] pay, input resp_t src_resp);
		id_t want_id;
		want_id = (p == 0) ? `ID_IFU : `ID_LSU;
		if (hold[p] && (!v || pay != last[p]))
			report_mismatch($sformatf("port %0d response changed while stalled", p));
		hold[p] = v & ~rdy;
		last[p] = pay;
		if (v) begin
			if (owner != p + 1 || ar_exp || aw_exp || w_exp) begin
				report_error($sformatf("response on port %0d with no matching request", p));
			end else if (rdy) begin
				if (p < 2 && pay[37:6] != (t_addr ^ rsp_key))
					report_mismatch($sformatf("port %0d data %h, addr %h", p, pay[37:6], t_addr));
				if (pay[5:4] != src_resp)
					report_mismatch($sformatf("port %0d resp %0d", p, pay[5:4]));
				if (pay[3:0] != want_id)
					report_mismatch($sformatf("port %0d id %0d", p, pay[3:0]));
				owner = 0; // one response closes the txn
				done_o++;
			end
		end
	endtask

	task automatic sample_cycle();
		int   n_acc;
		logic rsp_phase;
		// slave side readies follow the owner once every beat is out
		rsp_phase = (owner != 0) && !ar_exp && !aw_exp && !w_exp;
		if (axi_r_ready_o != (rsp_phase && ((owner == 1 && inst_r_ready_i) ||
			(owner == 2 && data_r_ready_i))))
			report_mismatch("r ready towards the slave");
		if (axi_b_ready_o != (rsp_phase && owner == 3 && data_b_ready_i))
			report_mismatch("b ready towards the slave");
		if (owner != 0 && device_o != t_dev)
			report_mismatch($sformatf("device %0d, expected %0d", device_o, t_dev));
		if (axi_ar_valid_o) begin
			if (!ar_exp) begin
				report_error("outbound ar valid with no read pending");
			end else if (axi_ar_ready_i) begin
				if (axi_ar_o.addr != t_addr) report_mismatch("ar address");
				if (axi_ar_o.id != ((owner == 1) ? `ID_IFU : `ID_LSU)) report_mismatch("ar id");
				if (axi_ar_o.size != t_size) report_mismatch("ar size");
				ar_exp = 1'b0;
			end
		end
		if (axi_aw_valid_o) begin
			if (!aw_exp) begin
				report_error("outbound aw valid with no write pending");
			end else if (axi_aw_ready_i) begin
				if (axi_aw_o.addr != t_addr) report_mismatch("aw address");
				if (axi_aw_o.id != `ID_LSU) report_mismatch("aw id");
				if (axi_aw_o.size != t_size) report_mismatch("aw size");
				aw_exp = 1'b0;
			end
		end
		if (axi_w_valid_o) begin
			if (!w_exp) begin
				report_error("outbound w valid with no write pending");
			end else if (axi_w_ready_i) begin
				if (axi_w_o != t_w) report_mismatch("w data or strobe");
				w_exp = 1'b0;
			end
		end
		// accepts
		n_acc = int'(data_aw_ready_o) + int'(data_ar_ready_o) + int'(inst_ar_ready_o);
		if (data_w_ready_o != data_aw_ready_o) report_mismatch("aw and w readies differ");
		if (owner != 0) begin
			if (n_acc != 0) report_error("request accepted while a transaction is outstanding");
		end else begin
			exp_kind = (data_aw_valid_i & data_w_valid_i) ? 3 : data_ar_valid_i ? 2 :
				inst_ar_valid_i ? 1 : 0;
			got_kind = data_aw_ready_o ? 3 : data_ar_ready_o ? 2 : inst_ar_ready_o ? 1 : 0;
			if (n_acc > 1 || got_kind != exp_kind)
				report_mismatch($sformatf("accepted kind %0d, expected %0d", got_kind, exp_kind));
			if (got_kind == 3) begin
				t_addr = data_aw_i.addr;
				t_size = data_aw_i.size;
				t_w    = data_w_i;
				t_dev  = map_dev(t_addr, 1'b1);
				aw_exp = 1'b1;
				w_exp  = 1'b1;
			end else if (got_kind == 2) begin
				t_addr = data_ar_i.addr;
				t_size = data_ar_i.size;
				t_dev  = map_dev(t_addr, 1'b0);
				ar_exp = 1'b1;
			end else if (got_kind == 1) begin
				t_addr = inst_ar_addr_i;
				t_size = `SIZE_WORD; // fetch always word sized
				t_dev  = map_dev(t_addr, 1'b0);
				ar_exp = 1'b1;
			end
			owner = got_kind;
		end
		check_response(0, inst_r_valid_o, inst_r_ready_i, inst_r_o, axi_r_i.resp);
		check_response(1, data_r_valid_o, data_r_ready_i, data_r_o, axi_r_i.resp);
		check_response(2, data_b_valid_o, data_b_ready_i, {32'd0, data_b_o}, axi_b_i.resp);
	endtask

	initial begin
		errors_o = 0;
		done_o = 0;
		owner = 0;
		ar_exp = 1'b0;
		aw_exp = 1'b0;
		w_exp = 1'b0;
		for (int i = 0; i < 3; i++) begin
			hold[i] = 1'b0;
			last[i] = '0;
		end
		forever begin
			@(negedge clock);
			#3; // just before the rising edge, all inputs settled
			if (!reset) sample_cycle();
		end
	end

endmodule

`default_nettype wire

// ==== tests/axi_ctl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_ctl_macros.svh"

module axi_ctl_tb;

	import axi_ctl_pkg::*;

	localparam int n_inst = 200; // fetches
	localparam int n_data = 200; // loads and stores
	localparam int max_cycles = (n_inst + n_data) * 50; // worst case per txn
	localparam data_t rsp_key = 32'h5a5a_c3c3; // read data = addr ^ key

	logic  clock;
	logic  reset;
	logic  inst_ar_valid_i;
	addr_t inst_ar_addr_i;
	logic  inst_ar_ready_o;
	r_t    inst_r_o;
	logic  inst_r_valid_o;
	logic  inst_r_ready_i;
	ar_t   data_ar_i;
	logic  data_ar_valid_i;
	logic  data_ar_ready_o;
	r_t    data_r_o;
	logic  data_r_valid_o;
	logic  data_r_ready_i;
	ar_t   data_aw_i;
	logic  data_aw_valid_i;
	logic  data_aw_ready_o;
	w_t    data_w_i;
	logic  data_w_valid_i;
	logic  data_w_ready_o;
	b_t    data_b_o;
	logic  data_b_valid_o;
	logic  data_b_ready_i;
	dev_t  device_o;
	ar_t   axi_ar_o;
	logic  axi_ar_valid_o;
	logic  axi_ar_ready_i;
	r_t    axi_r_i;
	logic  axi_r_valid_i;
	logic  axi_r_ready_o;
	ar_t   axi_aw_o;
	logic  axi_aw_valid_o;
	logic  axi_aw_ready_i;
	w_t    axi_w_o;
	logic  axi_w_valid_o;
	logic  axi_w_ready_i;
	b_t    axi_b_i;
	logic  axi_b_valid_i;
	logic  axi_b_ready_o;

	integer seed;
	int     cycles = 0;
	int     errors;
	int     done;

	axi_ctl_top axi_ctl_top_i (.*);

	axi_ctl_checker #(.rsp_key(rsp_key)) checker_i (
		.*,
		.errors_o (errors),
		.done_o   (done)
	);

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// mostly random word addresses, now and then a device register
	function automatic addr_t pick_addr();
		int sel;
		sel = rnd(8);
		if (sel == 0) return `SERIAL_PORT;
		if (sel == 1) return `RTC_ADDR;
		if (sel == 2) return `RTC_ADDR + 32'd4;
		return addr_t'($random(seed)) & ~32'd3;
	endfunction

	function automatic resp_t pick_resp();
		int r;
		r = rnd(8);
		if (r < 5) return 2'b00; // okay most of the time
		return resp_t'(r - 4);
	endfunction

	// called at a negedge with valid up, returns at the negedge after the handshake
	task automatic wait_accept(input int port);
		logic got;
		do begin
			#1;
			case (port)
				0: got = inst_ar_ready_o;
				1: got = data_ar_ready_o;
				default: got = data_aw_ready_o;
			endcase
			@(negedge clock);
		end while (!got);
	endtask

	// slave side ready pulse after a random wait
	task automatic accept_beat(input int ch);
		repeat (rnd(8)) @(negedge clock);
		case (ch)
			0: axi_ar_ready_i = 1'b1;
			1: axi_aw_ready_i = 1'b1;
			default: axi_w_ready_i = 1'b1;
		endcase
		@(negedge clock);
		axi_ar_ready_i = 1'b0;
		axi_aw_ready_i = 1'b0;
		axi_w_ready_i  = 1'b0;
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		seed = 32'hbb484385;
		reset = 1'b1;
		inst_ar_valid_i = 1'b0;
		inst_ar_addr_i = '0;
		inst_r_ready_i = 1'b0;
		data_ar_i = '0;
		data_ar_valid_i = 1'b0;
		data_r_ready_i = 1'b0;
		data_aw_i = '0;
		data_aw_valid_i = 1'b0;
		data_w_i = '0;
		data_w_valid_i = 1'b0;
		data_b_ready_i = 1'b0;
		axi_ar_ready_i = 1'b0;
		axi_aw_ready_i = 1'b0;
		axi_w_ready_i = 1'b0;
		axi_r_i = '0;
		axi_r_valid_i = 1'b0;
		axi_b_i = '0;
		axi_b_valid_i = 1'b0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	// fetch unit
	initial begin
		wait (reset == 1'b0);
		repeat (n_inst) begin
			repeat (rnd(6)) @(negedge clock); // random gap
			@(negedge clock);
			inst_ar_addr_i = pick_addr();
			inst_ar_valid_i = 1'b1;
			wait_accept(0);
			inst_ar_valid_i = 1'b0;
		end
	end

	// lsu, id and size are random, the dut forces the id
	initial begin : lsu
		int left;
		int kind;
		left = n_data;
		wait (reset == 1'b0);
		while (left > 0) begin
			repeat (rnd(6)) @(negedge clock);
			@(negedge clock);
			// 0 load, 1 store, 2 and 3 load and store together
			kind = (left > 1) ? rnd(4) : rnd(2);
			if (kind != 0) begin
				data_aw_i = '{addr: pick_addr(), id: 4'(rnd(16)), size: 3'(rnd(3))};
				data_w_i = '{data: $random(seed), strb: 4'(rnd(16))};
				data_w_valid_i = 1'b1;
				if (kind == 3) begin
					@(negedge clock); // data one cycle ahead of its address
				end
				data_aw_valid_i = 1'b1;
			end
			if (kind != 1) begin
				data_ar_i = '{addr: pick_addr(), id: 4'(rnd(16)), size: 3'(rnd(3))};
				data_ar_valid_i = 1'b1;
			end
			fork
				if (kind != 0) begin
					wait_accept(2);
					data_aw_valid_i = 1'b0;
					data_w_valid_i = 1'b0;
				end
				if (kind != 1) begin
					wait_accept(1);
					data_ar_valid_i = 1'b0;
				end
			join
			left -= (kind >= 2) ? 2 : 1;
		end
	end

	// upstream response readies drop at random
	initial begin
		forever begin
			@(negedge clock);
			inst_r_ready_i = (rnd(4) != 0);
			data_r_ready_i = (rnd(4) != 0);
			data_b_ready_i = (rnd(4) != 0);
		end
	end

	// slave model, one txn at a time
	initial begin : slave
		ar_t  req;
		logic got;
		wait (reset == 1'b0);
		forever begin
			@(negedge clock);
			#1;
			if (axi_ar_valid_o) begin
				req = axi_ar_o;
				accept_beat(0);
				repeat (rnd(8)) @(negedge clock);
				axi_r_i = '{data: req.addr ^ rsp_key, resp: pick_resp(), id: req.id};
				axi_r_valid_i = 1'b1;
				do begin
					#1;
					got = axi_r_ready_o;
					@(negedge clock);
				end while (!got);
				axi_r_valid_i = 1'b0;
			end else if (axi_aw_valid_o) begin
				req = axi_aw_o;
				accept_beat(1);
				accept_beat(2); // w still held by the dut
				repeat (rnd(8)) @(negedge clock);
				axi_b_i = '{resp: pick_resp(), id: req.id};
				axi_b_valid_i = 1'b1;
				do begin
					#1;
					got = axi_b_ready_o;
					@(negedge clock);
				end while (!got);
				axi_b_valid_i = 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, %0d of %0d transactions completed",
				cycles, done, n_inst + n_data);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		wait (reset == 1'b0);
		wait (done == n_inst + n_data);
		repeat (10) @(posedge clock); // let stray valids show up
		$display("errors: %0d, transactions completed: %0d", errors, done);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
